// File: tri_balancer.f
logic/mem_map_pkg.sv
logic/prim_order_pkg.sv
logic/vertex_fetch.sv
logic/vertex_slots.sv
logic/tri_dispatch.sv
logic/tri_balancer.sv
sim/tri_balancer_tb.sv

// File: sim/tri_balancer_tb.sv
module tri_balancer_tb;
    import mem_map_pkg::*;
    import prim_order_pkg::*;

    localparam int NUM_PIPES  = 2;
    localparam int RD_LAT     = 2;
    localparam int CLK_PERIOD = 40;
    localparam int MEM_DEPTH  = 1024;
    localparam int BUF_DEPTH  = 256;
    localparam int NUM_VERTS  = 11;
    localparam mem_addr_t I_PTR = 32'h40;
    localparam mem_addr_t V_PTR = 32'h100;

    logic                            clk;
    logic                            resetn;
    logic                            i_start;
    storage_mode_t                   i_mode;
    mem_addr_t                       i_v_array_ptr;
    mem_addr_t                       i_i_array_ptr;
    attr_idx_t                       i_vertex_size;
    tri_count_t                      i_total_tris;
    mem_word_t                       i_mem_rd_data;
    logic [NUM_PIPES-1:0]            i_fifo_full;
    logic                            o_ready;
    logic                            o_done;
    mem_addr_t                       o_mem_rd_addr;
    logic                            o_mem_rd_en;
    mem_word_t [NUM_PIPES-1:0]       o_fifo_wr_data;
    logic [NUM_PIPES-1:0]            o_fifo_wr_en;

    mem_word_t   mem [MEM_DEPTH];
    mem_addr_t   rd_addr_q;
    int          rd_wait;
    int          mem_reads;
    mem_word_t   got_buf [NUM_PIPES][BUF_DEPTH];
    int          got_n [NUM_PIPES];
    mem_word_t   exp_buf [NUM_PIPES][BUF_DEPTH];
    int          exp_n [NUM_PIPES];
    int          last_pipe;
    int          tris_seen;
    logic        bp_on;
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    tri_balancer #(
        .NUM_T_PIPES      (NUM_PIPES),
        .MEM_READ_LATENCY (RD_LAT)
    ) uut (
        .clk            (clk),
        .resetn         (resetn),
        .i_start        (i_start),
        .i_mode         (i_mode),
        .i_v_array_ptr  (i_v_array_ptr),
        .i_i_array_ptr  (i_i_array_ptr),
        .i_vertex_size  (i_vertex_size),
        .i_total_tris   (i_total_tris),
        .i_mem_rd_data  (i_mem_rd_data),
        .i_fifo_full    (i_fifo_full),
        .o_ready        (o_ready),
        .o_done         (o_done),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .o_mem_rd_en    (o_mem_rd_en),
        .o_fifo_wr_data (o_fifo_wr_data),
        .o_fifo_wr_en   (o_fifo_wr_en)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic rand_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic mem_word_t fill_word(int a);
        return mem_word_t'(a) ^ 32'hdead_beef;
    endfunction

    function automatic int idx_at(int k);
        return (k * 5 + 2) % NUM_VERTS;
    endfunction

    // vertex number in bits 15:8, attribute offset in the low byte
    function automatic mem_word_t vertex_word(int v, int a);
        return 32'h5a00_0000 | mem_word_t'(v << 8) | mem_word_t'(a);
    endfunction

    // rough upper bound in cycles for one run under back-pressure
    function automatic int run_cycles(int ntris, int vsize);
        return ntris * 3 * ((vsize + 2) * (RD_LAT + 3) + (vsize + 1) * 16) + 20;
    endfunction

    task automatic word_check(mem_word_t got, mem_word_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic count_check(tri_count_t got, tri_count_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic flag_check(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic clear_sinks();
        for (int p = 0; p < NUM_PIPES; p++) begin
            got_n[p] = 0;
        end
        last_pipe = -1;
        tris_seen = 0;
    endtask

    task automatic load_memory(int vsize);
        for (int a = 0; a < MEM_DEPTH; a++) begin
            mem[a] = fill_word(a);
        end
        for (int k = 0; k < 16; k++) begin
            mem[int'(I_PTR) + k] = mem_word_t'(idx_at(k));
        end
        for (int v = 0; v < NUM_VERTS; v++) begin
            for (int a = 0; a <= vsize; a++) begin
                mem[int'(V_PTR) + (vsize + 1) * v + a] = vertex_word(v, a);
            end
        end
    endtask

    // expected streams from the slot order and round-robin rules
    task automatic expect_run(storage_mode_t mode, int vsize, int ntris);
        int b;
        int s;
        int pos;
        int p;
        for (int q = 0; q < NUM_PIPES; q++) begin
            exp_n[q] = 0;
        end
        for (int t = 0; t < ntris; t++) begin
            b = t % 3;
            p = t % NUM_PIPES;
            for (int j = 0; j < 3; j++) begin
                if (mode == MODE_STRIP) begin
                    s = (t % 2 == 1) ? (b + 2 - j) % 3 : (b + j) % 3;
                    pos = t + (s + 3 - b) % 3;
                end else begin
                    pos = 3 * t + j;
                end
                for (int a = 0; a <= vsize; a++) begin
                    exp_buf[p][exp_n[p]] = vertex_word(idx_at(pos), a);
                    exp_n[p]++;
                end
            end
        end
    endtask

    task automatic compare_streams();
        for (int p = 0; p < NUM_PIPES; p++) begin
            count_check(tri_count_t'(got_n[p]), tri_count_t'(exp_n[p]), "pipe word count");
            for (int i = 0; i < got_n[p] && i < exp_n[p]; i++) begin
                word_check(got_buf[p][i], exp_buf[p][i], $sformatf("pipe %0d word %0d", p, i));
            end
        end
    endtask

    task automatic run_tris(storage_mode_t mode, int vsize, int ntris);
        @(negedge clk);
        load_memory(vsize);
        expect_run(mode, vsize, ntris);
        clear_sinks();
        mem_reads     = 0;
        i_mode        = mode;
        i_vertex_size = attr_idx_t'(vsize);
        i_total_tris  = tri_count_t'(ntris);
        i_start       = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        while (!o_done) begin
            @(negedge clk);
        end
        flag_check(o_ready, 1'b1, "o_ready with o_done");
        @(negedge clk);
        compare_streams();
    endtask

    task automatic reset_values();
        flag_check(o_ready, 1'b1, "o_ready after reset");
        flag_check(o_done, 1'b0, "o_done after reset");
        flag_check(o_mem_rd_en, 1'b0, "o_mem_rd_en after reset");
        for (int p = 0; p < NUM_PIPES; p++) begin
            flag_check(o_fifo_wr_en[p], 1'b0, $sformatf("o_fifo_wr_en[%0d] after reset", p));
        end
    endtask

    task automatic zero_tri_run();
        run_tris(MODE_TRIANGLES, 2, 0);
        count_check(tri_count_t'(mem_reads), '0, "memory reads on empty run");
    endtask

    task automatic individual_run();
        run_tris(MODE_TRIANGLES, 2, 4);
        count_check(tri_count_t'(tris_seen), tri_count_t'(4), "triangles delivered");
    endtask

    task automatic strip_run();
        run_tris(MODE_STRIP, 2, 5);
    endtask

    task automatic strip_under_back_pressure();
        @(posedge clk);
        bp_on = 1'b1;
        run_tris(MODE_STRIP, 2, 5);
        @(posedge clk);
        bp_on = 1'b0;
    endtask

    // pipe counter and parity are left mid-cycle by the previous strip run
    task automatic restart_after_done();
        run_tris(MODE_STRIP, 1, 4);
    endtask

    // memory model holds the data on the bus until the next read returns
    always @(negedge clk) begin
        if (rd_wait != 0) begin
            rd_wait = rd_wait - 1;
            if (rd_wait == 0) begin
                if (rd_addr_q < MEM_DEPTH) begin
                    i_mem_rd_data = mem[int'(rd_addr_q)];
                end else begin
                    i_mem_rd_data = fill_word(int'(rd_addr_q));
                end
            end
        end
        if (o_mem_rd_en) begin
            rd_addr_q = o_mem_rd_addr;
            rd_wait   = RD_LAT;
            mem_reads++;
        end
    end

    always @(negedge clk) begin
        for (int p = 0; p < NUM_PIPES; p++) begin
            i_fifo_full[p] = bp_on ? rand_bit() : 1'b0;
        end
    end

    // pipe sinks capture at the edge that writes the FIFO
    always @(posedge clk) begin
        for (int p = 0; p < NUM_PIPES; p++) begin
            if (o_fifo_wr_en[p]) begin
                if (i_fifo_full[p]) begin
                    errors++;
                    $display("error at %0t: pipe %0d written while full", $time, p);
                end
                // each change of the written pipe marks the start of a triangle
                if (p != last_pipe) begin
                    tris_seen++;
                end
                last_pipe = p;
                if (got_n[p] < BUF_DEPTH) begin
                    got_buf[p][got_n[p]] = o_fifo_wr_data[p];
                end
                got_n[p]++;
            end
        end
    end

    initial begin
        int limit;
        limit = 100 + run_cycles(0, 2) + run_cycles(4, 2) + 2 * run_cycles(5, 2)
                + run_cycles(4, 1);
        #(limit * CLK_PERIOD);
        $display("timeout: the DUT did not finish all runs within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        resetn        = 1'b0;
        i_start       = 1'b0;
        i_mode        = MODE_TRIANGLES;
        i_v_array_ptr = V_PTR;
        i_i_array_ptr = I_PTR;
        i_vertex_size = '0;
        i_total_tris  = '0;
        i_mem_rd_data = '0;
        i_fifo_full   = '0;
        rd_addr_q     = '0;
        rd_wait       = 0;
        mem_reads     = 0;
        clear_sinks();
        for (int q = 0; q < NUM_PIPES; q++) begin
            exp_n[q] = 0;
        end
        bp_on         = 1'b0;
        lfsr_state    = 32'hc627;
        errors        = 0;
        checks        = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        reset_values();
        zero_tri_run();
        individual_run();
        strip_run();
        strip_under_back_pressure();
        restart_after_done();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: logic/tri_balancer.sv
module tri_balancer #(
    parameter int NUM_T_PIPES      = 2,
    parameter int MEM_READ_LATENCY = 2
) (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  logic                                      i_start,
    input  prim_order_pkg::storage_mode_t             i_mode,
    input  mem_map_pkg::mem_addr_t                    i_v_array_ptr,
    input  mem_map_pkg::mem_addr_t                    i_i_array_ptr,
    input  mem_map_pkg::attr_idx_t                    i_vertex_size,
    input  prim_order_pkg::tri_count_t                i_total_tris,
    input  mem_map_pkg::mem_word_t                    i_mem_rd_data,
    input  logic [NUM_T_PIPES-1:0]                    i_fifo_full,
    output logic                                      o_ready,
    output logic                                      o_done,
    output mem_map_pkg::mem_addr_t                    o_mem_rd_addr,
    output logic                                      o_mem_rd_en,
    output mem_map_pkg::mem_word_t [NUM_T_PIPES-1:0]  o_fifo_wr_data,
    output logic [NUM_T_PIPES-1:0]                    o_fifo_wr_en
);
    import mem_map_pkg::*;
    import prim_order_pkg::*;

    // fetch side into the slot store
    logic      slot_wr_en;
    slot_idx_t slot_wr_slot;
    attr_idx_t slot_wr_attr;
    mem_word_t slot_wr_data;

    // dispatch side out of the slot store
    slot_idx_t slot_rd_slot;
    attr_idx_t slot_rd_attr;
    mem_word_t slot_rd_data;

    // one triangle in flight between fetch and dispatch
    logic run_start;
    logic tri_loaded;
    logic tri_sent;

    vertex_fetch #(
        .MEM_READ_LATENCY (MEM_READ_LATENCY)
    ) u_vertex_fetch (
        .clk            (clk),
        .resetn         (resetn),
        .i_start        (i_start),
        .i_mode         (i_mode),
        .i_v_array_ptr  (i_v_array_ptr),
        .i_i_array_ptr  (i_i_array_ptr),
        .i_vertex_size  (i_vertex_size),
        .i_total_tris   (i_total_tris),
        .i_mem_rd_data  (i_mem_rd_data),
        .i_tri_sent     (tri_sent),
        .o_ready        (o_ready),
        .o_done         (o_done),
        .o_mem_rd_addr  (o_mem_rd_addr),
        .o_mem_rd_en    (o_mem_rd_en),
        .o_slot_wr_en   (slot_wr_en),
        .o_slot_wr_slot (slot_wr_slot),
        .o_slot_wr_attr (slot_wr_attr),
        .o_slot_wr_data (slot_wr_data),
        .o_run_start    (run_start),
        .o_tri_loaded   (tri_loaded)
    );

    vertex_slots u_vertex_slots (
        .clk       (clk),
        .resetn    (resetn),
        .i_wr_en   (slot_wr_en),
        .i_wr_slot (slot_wr_slot),
        .i_wr_attr (slot_wr_attr),
        .i_wr_data (slot_wr_data),
        .i_rd_slot (slot_rd_slot),
        .i_rd_attr (slot_rd_attr),
        .o_rd_data (slot_rd_data)
    );

    tri_dispatch #(
        .NUM_T_PIPES (NUM_T_PIPES)
    ) u_tri_dispatch (
        .clk            (clk),
        .resetn         (resetn),
        .i_mode         (i_mode),
        .i_vertex_size  (i_vertex_size),
        .i_run_start    (run_start),
        .i_tri_loaded   (tri_loaded),
        .i_rd_data      (slot_rd_data),
        .i_fifo_full    (i_fifo_full),
        .o_rd_slot      (slot_rd_slot),
        .o_rd_attr      (slot_rd_attr),
        .o_fifo_wr_data (o_fifo_wr_data),
        .o_fifo_wr_en   (o_fifo_wr_en),
        .o_tri_sent     (tri_sent)
    );

endmodule

// File: logic/tri_dispatch.sv
module tri_dispatch #(
    parameter int NUM_T_PIPES = 2
) (
    input  logic                                      clk,
    input  logic                                      resetn,
    input  prim_order_pkg::storage_mode_t             i_mode,
    input  mem_map_pkg::attr_idx_t                    i_vertex_size,
    input  logic                                      i_run_start,
    input  logic                                      i_tri_loaded,
    input  mem_map_pkg::mem_word_t                    i_rd_data,
    input  logic [NUM_T_PIPES-1:0]                    i_fifo_full,
    output prim_order_pkg::slot_idx_t                 o_rd_slot,
    output mem_map_pkg::attr_idx_t                    o_rd_attr,
    output mem_map_pkg::mem_word_t [NUM_T_PIPES-1:0]  o_fifo_wr_data,
    output logic [NUM_T_PIPES-1:0]                    o_fifo_wr_en,
    output logic                                      o_tri_sent
);
    import mem_map_pkg::*;
    import prim_order_pkg::*;

    localparam int PIPE_W = (NUM_T_PIPES > 1) ? $clog2(NUM_T_PIPES) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t            state;
    logic [PIPE_W-1:0] pipe;
    logic              odd;
    slot_idx_t         base;
    logic [1:0]        vert_cnt;
    attr_idx_t         attr;
    logic              reverse;
    logic              pipe_full;

    // (a + b) mod 3 for slot numbers
    function automatic slot_idx_t slot_add(slot_idx_t a, logic [1:0] b);
        logic [2:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= 3'(SLOTS_PER_TRI)) begin
            sum = sum - 3'(SLOTS_PER_TRI);
        end
        return slot_idx_t'(sum);
    endfunction

    // odd strip triangles go out in reversed order to keep the winding
    assign reverse   = (i_mode == MODE_STRIP) && odd;
    assign pipe_full = i_fifo_full[pipe];

    assign o_rd_slot = reverse ? slot_add(base, 2'd2 - vert_cnt) : slot_add(base, vert_cnt);
    assign o_rd_attr = attr;

    // every pipe sees the slot word, only the selected one is enabled
    always_comb begin
        o_fifo_wr_en = '0;
        for (int p = 0; p < NUM_T_PIPES; p++) begin
            o_fifo_wr_data[p] = i_rd_data;
        end
        if (state == ST_WRITE && !pipe_full) begin
            o_fifo_wr_en[pipe] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            pipe       <= '0;
            odd        <= 1'b0;
            base       <= '0;
            vert_cnt   <= '0;
            attr       <= '0;
            o_tri_sent <= 1'b0;
        end else begin
            o_tri_sent <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_run_start) begin
                        pipe <= '0;
                        odd  <= 1'b0;
                        base <= '0;
                    end
                    if (i_tri_loaded) begin
                        vert_cnt <= '0;
                        attr     <= '0;
                        state    <= ST_READ;
                    end
                end
                ST_READ: begin
                    // the slot bank samples the address at this edge
                    if (!pipe_full) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (!pipe_full) begin
                        if (attr != i_vertex_size) begin
                            attr  <= attr + 1'b1;
                            state <= ST_READ;
                        end else if (vert_cnt != 2'(SLOTS_PER_TRI - 1)) begin
                            attr     <= '0;
                            vert_cnt <= vert_cnt + 1'b1;
                            state    <= ST_READ;
                        end else begin
                            attr       <= '0;
                            vert_cnt   <= '0;
                            o_tri_sent <= 1'b1;
                            state      <= ST_IDLE;
                            if (pipe == PIPE_W'(NUM_T_PIPES - 1)) begin
                                pipe <= '0;
                            end else begin
                                pipe <= pipe + 1'b1;
                            end
                            // strip base slot follows the oldest vertex kept
                            if (i_mode == MODE_STRIP) begin
                                odd  <= ~odd;
                                base <= slot_add(base, 2'd1);
                            end
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/vertex_slots.sv
module vertex_slots (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      i_wr_en,
    input  prim_order_pkg::slot_idx_t i_wr_slot,
    input  mem_map_pkg::attr_idx_t    i_wr_attr,
    input  mem_map_pkg::mem_word_t    i_wr_data,
    input  prim_order_pkg::slot_idx_t i_rd_slot,
    input  mem_map_pkg::attr_idx_t    i_rd_attr,
    output mem_map_pkg::mem_word_t    o_rd_data
);
    import mem_map_pkg::*;
    import prim_order_pkg::*;

    // one bank of attribute words per vertex of the triangle;
    // in strip mode two banks carry over into the next triangle
    mem_word_t slot_mem [SLOTS_PER_TRI][ATTR_DEPTH];

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            slot_mem[i_wr_slot][i_wr_attr] <= i_wr_data;
        end
    end

    // registered read, the word follows the address by one cycle
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_rd_data <= '0;
        end else begin
            o_rd_data <= slot_mem[i_rd_slot][i_rd_attr];
        end
    end

endmodule

// File: logic/vertex_fetch.sv
module vertex_fetch #(
    parameter int MEM_READ_LATENCY = 2
) (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          i_start,
    input  prim_order_pkg::storage_mode_t i_mode,
    input  mem_map_pkg::mem_addr_t        i_v_array_ptr,
    input  mem_map_pkg::mem_addr_t        i_i_array_ptr,
    input  mem_map_pkg::attr_idx_t        i_vertex_size,
    input  prim_order_pkg::tri_count_t    i_total_tris,
    input  mem_map_pkg::mem_word_t        i_mem_rd_data,
    input  logic                          i_tri_sent,
    output logic                          o_ready,
    output logic                          o_done,
    output mem_map_pkg::mem_addr_t        o_mem_rd_addr,
    output logic                          o_mem_rd_en,
    output logic                          o_slot_wr_en,
    output prim_order_pkg::slot_idx_t     o_slot_wr_slot,
    output mem_map_pkg::attr_idx_t        o_slot_wr_attr,
    output mem_map_pkg::mem_word_t        o_slot_wr_data,
    output logic                          o_run_start,
    output logic                          o_tri_loaded
);
    import mem_map_pkg::*;
    import prim_order_pkg::*;

    localparam int WAIT_W = $clog2(MEM_READ_LATENCY + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_IDX_WAIT,
        ST_IDX_USE,
        ST_ATTR_WAIT,
        ST_ATTR_USE,
        ST_LOADED,
        ST_SEND
    } state_t;

    state_t      state;
    logic [WAIT_W-1:0] wait_cnt;
    tri_count_t  tri_cnt;
    mem_addr_t   idx_pos;
    mem_addr_t   vtx_addr;
    attr_idx_t   attr;
    slot_idx_t   wr_slot;
    logic [1:0]  verts_left;
    mem_addr_t   vertex_words;
    mem_addr_t   vtx_base;

    assign vertex_words = mem_addr_t'(i_vertex_size) + mem_addr_t'(1);
    // first attribute word of the vertex whose index is on the read bus
    assign vtx_base = i_v_array_ptr + vertex_words * mem_addr_t'(i_mem_rd_data);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state          <= ST_IDLE;
            wait_cnt       <= '0;
            tri_cnt        <= '0;
            idx_pos        <= '0;
            vtx_addr       <= '0;
            attr           <= '0;
            wr_slot        <= '0;
            verts_left     <= '0;
            o_ready        <= 1'b1;
            o_done         <= 1'b0;
            o_mem_rd_addr  <= '0;
            o_mem_rd_en    <= 1'b0;
            o_slot_wr_en   <= 1'b0;
            o_slot_wr_slot <= '0;
            o_slot_wr_attr <= '0;
            o_slot_wr_data <= '0;
            o_run_start    <= 1'b0;
            o_tri_loaded   <= 1'b0;
        end else begin
            // strobes last one cycle
            o_done       <= 1'b0;
            o_mem_rd_en  <= 1'b0;
            o_slot_wr_en <= 1'b0;
            o_run_start  <= 1'b0;
            o_tri_loaded <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        o_ready     <= 1'b0;
                        o_run_start <= 1'b1;
                        tri_cnt     <= '0;
                        idx_pos     <= '0;
                        wr_slot     <= '0;
                        state       <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    if (tri_cnt == i_total_tris) begin
                        o_done  <= 1'b1;
                        o_ready <= 1'b1;
                        state   <= ST_IDLE;
                    end else begin
                        // a strip needs only one new vertex after its first triangle
                        if (i_mode == MODE_STRIP && tri_cnt != '0) begin
                            verts_left <= 2'd0;
                        end else begin
                            verts_left <= 2'(SLOTS_PER_TRI - 1);
                        end
                        o_mem_rd_addr <= i_i_array_ptr + idx_pos;
                        o_mem_rd_en   <= 1'b1;
                        wait_cnt      <= '0;
                        state         <= ST_IDX_WAIT;
                    end
                end
                ST_IDX_WAIT, ST_ATTR_WAIT: begin
                    if (wait_cnt == WAIT_W'(MEM_READ_LATENCY)) begin
                        state <= (state == ST_IDX_WAIT) ? ST_IDX_USE : ST_ATTR_USE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ST_IDX_USE: begin
                    vtx_addr      <= vtx_base;
                    attr          <= '0;
                    o_mem_rd_addr <= vtx_base;
                    o_mem_rd_en   <= 1'b1;
                    wait_cnt      <= '0;
                    state         <= ST_ATTR_WAIT;
                end
                ST_ATTR_USE: begin
                    o_slot_wr_en   <= 1'b1;
                    o_slot_wr_slot <= wr_slot;
                    o_slot_wr_attr <= attr;
                    o_slot_wr_data <= i_mem_rd_data;
                    wait_cnt       <= '0;
                    if (attr != i_vertex_size) begin
                        attr          <= attr + 1'b1;
                        o_mem_rd_addr <= vtx_addr + mem_addr_t'(attr) + mem_addr_t'(1);
                        o_mem_rd_en   <= 1'b1;
                        state         <= ST_ATTR_WAIT;
                    end else begin
                        // index position k always lands in slot k mod 3
                        idx_pos <= idx_pos + 1'b1;
                        if (wr_slot == slot_idx_t'(SLOTS_PER_TRI - 1)) begin
                            wr_slot <= '0;
                        end else begin
                            wr_slot <= wr_slot + 1'b1;
                        end
                        if (verts_left != 2'd0) begin
                            verts_left    <= verts_left - 1'b1;
                            o_mem_rd_addr <= i_i_array_ptr + idx_pos + mem_addr_t'(1);
                            o_mem_rd_en   <= 1'b1;
                            state         <= ST_IDX_WAIT;
                        end else begin
                            state <= ST_LOADED;
                        end
                    end
                end
                ST_LOADED: begin
                    // last slot write lands at the end of this cycle
                    o_tri_loaded <= 1'b1;
                    state        <= ST_SEND;
                end
                ST_SEND: begin
                    if (i_tri_sent) begin
                        tri_cnt <= tri_cnt + 1'b1;
                        state   <= ST_CHECK;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: logic/prim_order_pkg.sv
package prim_order_pkg;

    // how the index array describes the primitives
    //   MODE_TRIANGLES: triangle t uses indices 3t, 3t+1, 3t+2
    //   MODE_STRIP:     triangle t uses indices t, t+1, t+2
    typedef enum logic {
        MODE_TRIANGLES = 1'b0,
        MODE_STRIP     = 1'b1
    } storage_mode_t;

    // vertices held locally for the triangle in flight
    localparam int SLOTS_PER_TRI = 3;

    // local vertex slot, only 0 to 2 are used
    typedef logic [1:0] slot_idx_t;

    localparam int TRI_COUNT_W = 16;

    // triangle count of one run
    typedef logic [TRI_COUNT_W-1:0] tri_count_t;

endpackage

// File: logic/mem_map_pkg.sv
package mem_map_pkg;

    // main memory data word, holds an index or a vertex attribute
    localparam int MEM_WORD_W = 32;

    // main memory word address
    localparam int MEM_ADDR_W = 32;

    // attribute offset inside a vertex, also the local slot address
    localparam int ATTR_IDX_W = 4;

    // number of attribute words one local slot can hold
    localparam int ATTR_DEPTH = 1 << ATTR_IDX_W;

    typedef logic [MEM_WORD_W-1:0] mem_word_t;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // vertex size is given as words per vertex minus one,
    // so a full 4-bit value means 16 words
    typedef logic [ATTR_IDX_W-1:0] attr_idx_t;

endpackage
